//--- polar_alu_pkg.sv
`default_nettype none

package polar_alu_pkg;

    // ------------------------------
    // Operator encoding
    // ------------------------------
    typedef enum logic [5:0] {
        // Adder
        ADD, SUB, ADDW, SUBW,
        // Logic unit
        XORL, ORL, ANDL,
        // Shifter
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        // Set less than
        SLTS, SLTU,
        // Branch comparisons
        EQ, NE, LTS, LTU, GES, GEU,
        // Polar decoding SIMD ops
        PL_R, PL_F, PL_SUBSAT, PL_ADDSAT, PL_DECODE, PL_EVAL,
        PL_VADDREP1, PL_VADDREP2, PL_VREPSUM
    } alu_op_e;

    // Result source picked by the output mux
    typedef enum logic [2:0] {
        RES_NONE,
        RES_POLAR,
        RES_ADD,
        RES_ADDW,
        RES_SHIFT,
        RES_SHIFTW,
        RES_LOGIC,
        RES_LESS
    } res_sel_e;

    // ------------------------------
    // Lane constants
    // ------------------------------
    localparam int unsigned LANE_W = 8;
    // Symmetric clamp, -128 is never produced
    localparam int SAT_MAX = 127;
    // Replicate ops only look at the low word
    localparam int unsigned REP_W = 4 * LANE_W;

    // Low word seen as four LLR bytes or as two 16-bit partial sums
    typedef union packed {
        logic [3:0][LANE_W-1:0]   lanes;
        logic [1:0][2*LANE_W-1:0] halves;
    } rep_word_u;

    function automatic logic is_polar_op(input alu_op_e op);
        return op inside {PL_R, PL_F, PL_SUBSAT, PL_ADDSAT, PL_DECODE,
                          PL_EVAL, PL_VADDREP1, PL_VADDREP2, PL_VREPSUM};
    endfunction

endpackage

`default_nettype wire

//--- int_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module int_datapath #(
    parameter int unsigned XLEN = 64
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire polar_alu_pkg::alu_op_e operator_i,
    input  wire logic [XLEN-1:0]        operand_a_i,
    input  wire logic [XLEN-1:0]        operand_b_i,
    output logic [XLEN-1:0]             adder_result_o,
    output logic [XLEN-1:0]             shift_result_o,
    output logic [31:0]                 shift_result32_o,
    output logic [XLEN-1:0]             logic_result_o,
    output logic                        less_o,
    output logic                        adder_zero_o
);

    import polar_alu_pkg::*;

    localparam int unsigned SHAMT_W = $clog2(XLEN);

    // ------------------------------
    // Adder
    // ------------------------------
    logic          negate_b;
    logic [XLEN:0] adder_in_a;
    logic [XLEN:0] adder_in_b;
    logic [XLEN:0] adder_sum;

    always_comb begin
        case (operator_i)
            SUB, SUBW, EQ, NE: negate_b = 1'b1;
            default:           negate_b = 1'b0;
        endcase
    end

    // Extra LSB carries the +1 of the two's complement
    assign adder_in_a = {operand_a_i, 1'b1};
    assign adder_in_b = {operand_b_i, 1'b0} ^ {(XLEN+1){negate_b}};
    assign adder_sum  = adder_in_a + adder_in_b;

    assign adder_result_o = adder_sum[XLEN:1];
    assign adder_zero_o   = ~|adder_result_o;

    // ------------------------------
    // Shifter
    // ------------------------------
    logic            shift_left;
    logic            shift_arith;
    logic [XLEN-1:0] a_rev;
    logic [31:0]     a_rev32;
    logic [XLEN-1:0] shift_in;
    logic [31:0]     shift_in32;
    logic [XLEN:0]   shift_right;
    logic [32:0]     shift_right32;
    logic [XLEN-1:0] shift_right_rev;
    logic [31:0]     shift_right_rev32;

    assign shift_left  = (operator_i == SLL) || (operator_i == SLLW);
    assign shift_arith = (operator_i == SRA) || (operator_i == SRAW);

    // Left shift = reverse, shift right, reverse back
    for (genvar i = 0; i < XLEN; i++) begin : g_rev
        assign a_rev[i]           = operand_a_i[XLEN-1-i];
        assign shift_right_rev[i] = shift_right[XLEN-1-i];
    end

    for (genvar i = 0; i < 32; i++) begin : g_rev32
        assign a_rev32[i]           = operand_a_i[31-i];
        assign shift_right_rev32[i] = shift_right32[31-i];
    end

    assign shift_in   = shift_left ? a_rev : operand_a_i;
    assign shift_in32 = shift_left ? a_rev32 : operand_a_i[31:0];

    // Fill bit is the sign only for arithmetic shifts
    assign shift_right = $unsigned(
        $signed({shift_arith & shift_in[XLEN-1], shift_in}) >>> operand_b_i[SHAMT_W-1:0]
    );
    assign shift_right32 = $unsigned(
        $signed({shift_arith & shift_in32[31], shift_in32}) >>> operand_b_i[4:0]
    );

    assign shift_result_o   = shift_left ? shift_right_rev : shift_right[XLEN-1:0];
    assign shift_result32_o = shift_left ? shift_right_rev32 : shift_right32[31:0];

    // ------------------------------
    // Comparator
    // ------------------------------
    logic signed_cmp;

    assign signed_cmp = operator_i inside {SLTS, LTS, GES};

    // One extra bit turns both forms into a signed compare
    assign less_o = $signed({signed_cmp & operand_a_i[XLEN-1], operand_a_i})
                  < $signed({signed_cmp & operand_b_i[XLEN-1], operand_b_i});

    // ------------------------------
    // Logic unit
    // ------------------------------
    always_comb begin
        case (operator_i)
            XORL:    logic_result_o = operand_a_i ^ operand_b_i;
            ORL:     logic_result_o = operand_a_i | operand_b_i;
            ANDL:    logic_result_o = operand_a_i & operand_b_i;
            default: logic_result_o = '0;
        endcase
    end

    // Branch on equal relies on the subtracting adder
    a_eq_zero_flag: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (operator_i == EQ) |-> (adder_zero_o == (operand_a_i == operand_b_i))
    );

endmodule

`default_nettype wire

//--- polar_simd_unit.sv
`timescale 1ns/1ps
`default_nettype none

module polar_simd_unit #(
    parameter int unsigned XLEN = 64
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire polar_alu_pkg::alu_op_e operator_i,
    input  wire logic [XLEN-1:0]        operand_a_i,
    input  wire logic [XLEN-1:0]        operand_b_i,
    output logic [XLEN-1:0]             polar_result_o
);

    import polar_alu_pkg::*;

    localparam int unsigned LANES = XLEN / LANE_W;

    // Clamp a 9-bit lane result to the symmetric range
    function automatic logic [LANE_W-1:0] clamp_lane(input logic signed [LANE_W:0] v);
        if (v > SAT_MAX) begin
            return LANE_W'(SAT_MAX);
        end
        if (v < -SAT_MAX) begin
            return LANE_W'(-SAT_MAX);
        end
        return v[LANE_W-1:0];
    endfunction

    function automatic logic [2*LANE_W-1:0] sext_lane(input logic [LANE_W-1:0] v);
        return {{LANE_W{v[LANE_W-1]}}, v};
    endfunction

    // One byte per half, 1 when the half is negative
    function automatic logic [LANE_W-1:0] half_sign(input logic [2*LANE_W-1:0] h);
        return LANE_W'(h[2*LANE_W-1]);
    endfunction

    logic [XLEN-1:0]  func_r;
    logic [XLEN-1:0]  func_f;
    logic [XLEN-1:0]  func_subsat;
    logic [XLEN-1:0]  func_addsat;
    logic [XLEN-1:0]  func_decode;
    logic [XLEN-1:0]  func_eval;
    logic [REP_W-1:0] rep_add1;
    logic [REP_W-1:0] rep_add2;
    logic [REP_W-1:0] rep_sum;
    rep_word_u        a_rep;
    rep_word_u        b_rep;

    // ------------------------------
    // Per-lane operations
    // ------------------------------
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic signed [LANE_W-1:0] a_l;
        logic signed [LANE_W-1:0] b_l;
        logic [LANE_W-1:0]        abs_a;
        logic [LANE_W-1:0]        abs_b;
        logic [LANE_W-1:0]        min_mag;
        logic signed [LANE_W:0]   sum;
        logic signed [LANE_W:0]   diff;

        assign a_l = operand_a_i[i*LANE_W +: LANE_W];
        assign b_l = operand_b_i[i*LANE_W +: LANE_W];

        // Hard decision, forced to zero for a frozen bit
        assign func_r[i*LANE_W +: LANE_W] = (operand_b_i[LANE_W-1:0] == LANE_W'(1)) ? '0
                                            : LANE_W'(a_l[LANE_W-1]);

        assign func_decode[i*LANE_W +: LANE_W] = (operand_b_i[LANE_W-1:0] == '0) ? a_l : '0;

        assign func_eval[i*LANE_W +: LANE_W] = (a_l == LANE_W'(1)) ? '1 : '0;

        // Min-sum f: smaller magnitude, sign is the product of signs
        // -128 has magnitude 0x80, read unsigned
        assign abs_a   = a_l[LANE_W-1] ? -a_l : a_l;
        assign abs_b   = b_l[LANE_W-1] ? -b_l : b_l;
        assign min_mag = (abs_a > abs_b) ? abs_b : abs_a;

        assign func_f[i*LANE_W +: LANE_W] = (a_l[LANE_W-1] ^ b_l[LANE_W-1]) ? -min_mag
                                            : min_mag;

        // Saturating ops on 9 bits so overflow is visible
        assign sum  = {a_l[LANE_W-1], a_l} + {b_l[LANE_W-1], b_l};
        assign diff = {a_l[LANE_W-1], a_l} - {b_l[LANE_W-1], b_l};

        assign func_addsat[i*LANE_W +: LANE_W] = clamp_lane(sum);
        assign func_subsat[i*LANE_W +: LANE_W] = clamp_lane(diff);

        a_sat_no_min: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            (operator_i inside {PL_ADDSAT, PL_SUBSAT})
                |-> (polar_result_o[i*LANE_W +: LANE_W] != 8'h80)
        );
    end

    // ------------------------------
    // Replicate ops on the low word
    // ------------------------------
    assign a_rep = operand_a_i[REP_W-1:0];
    assign b_rep = operand_b_i[REP_W-1:0];

    assign rep_add1 = {a_rep.halves[1] + sext_lane(b_rep.lanes[1]),
                       a_rep.halves[0] + sext_lane(b_rep.lanes[0])};

    assign rep_add2 = {a_rep.halves[1] + sext_lane(b_rep.lanes[3]),
                       a_rep.halves[0] + sext_lane(b_rep.lanes[2])};

    // MSB byte down: A high, A low, B high, B low
    assign rep_sum = {half_sign(a_rep.halves[1]), half_sign(a_rep.halves[0]),
                      half_sign(b_rep.halves[1]), half_sign(b_rep.halves[0])};

    always_comb begin
        polar_result_o = '0;
        if (is_polar_op(operator_i)) begin
            case (operator_i)
                PL_R:        polar_result_o = func_r;
                PL_F:        polar_result_o = func_f;
                PL_SUBSAT:   polar_result_o = func_subsat;
                PL_ADDSAT:   polar_result_o = func_addsat;
                PL_DECODE:   polar_result_o = func_decode;
                PL_EVAL:     polar_result_o = func_eval;
                PL_VADDREP1: polar_result_o = XLEN'(rep_add1);
                PL_VADDREP2: polar_result_o = XLEN'(rep_add2);
                PL_VREPSUM:  polar_result_o = XLEN'(rep_sum);
                default:     polar_result_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- alu_result_select.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result_select #(
    parameter int unsigned XLEN = 64
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire polar_alu_pkg::alu_op_e operator_i,
    input  wire logic [XLEN-1:0]        adder_result_i,
    input  wire logic [XLEN-1:0]        shift_result_i,
    input  wire logic [31:0]            shift_result32_i,
    input  wire logic [XLEN-1:0]        logic_result_i,
    input  wire logic                   less_i,
    input  wire logic                   adder_zero_i,
    input  wire logic [XLEN-1:0]        polar_result_i,
    output logic [XLEN-1:0]             result_o,
    output logic                        branch_res_o
);

    import polar_alu_pkg::*;

    res_sel_e res_sel;

    // ------------------------------
    // Operator decode
    // ------------------------------
    always_comb begin
        if (is_polar_op(operator_i)) begin
            res_sel = RES_POLAR;
        end else begin
            case (operator_i)
                ADD, SUB:         res_sel = RES_ADD;
                ADDW, SUBW:       res_sel = RES_ADDW;
                SLL, SRL, SRA:    res_sel = RES_SHIFT;
                SLLW, SRLW, SRAW: res_sel = RES_SHIFTW;
                XORL, ORL, ANDL:  res_sel = RES_LOGIC;
                SLTS, SLTU:       res_sel = RES_LESS;
                default:          res_sel = RES_NONE;
            endcase
        end
    end

    // Word forms sign-extend from bit 31
    always_comb begin
        case (res_sel)
            RES_POLAR:  result_o = polar_result_i;
            RES_ADD:    result_o = adder_result_i;
            RES_ADDW:   result_o = XLEN'($signed(adder_result_i[31:0]));
            RES_SHIFT:  result_o = shift_result_i;
            RES_SHIFTW: result_o = XLEN'($signed(shift_result32_i));
            RES_LOGIC:  result_o = logic_result_i;
            RES_LESS:   result_o = XLEN'(less_i);
            default:    result_o = '0;
        endcase
    end

    // Taken unless a branch compare says otherwise
    always_comb begin
        case (operator_i)
            EQ:       branch_res_o = adder_zero_i;
            NE:       branch_res_o = ~adder_zero_i;
            LTS, LTU: branch_res_o = less_i;
            GES, GEU: branch_res_o = ~less_i;
            default:  branch_res_o = 1'b1;
        endcase
    end

    // Every operator that produces a result leaves the branch taken
    a_branch_default: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (res_sel != RES_NONE) |-> branch_res_o
    );

endmodule

`default_nettype wire

//--- polar_alu.sv
`timescale 1ns/1ps
`default_nettype none

module polar_alu #(
    parameter int unsigned XLEN = 64
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire polar_alu_pkg::alu_op_e operator_i,
    input  wire logic [XLEN-1:0]        operand_a_i,
    input  wire logic [XLEN-1:0]        operand_b_i,
    output logic [XLEN-1:0]             result_o,
    output logic                        branch_res_o
);

    // Raw integer results
    logic [XLEN-1:0] adder_result;
    logic [XLEN-1:0] shift_result;
    logic [31:0]     shift_result32;
    logic [XLEN-1:0] logic_result;
    logic            less;
    logic            adder_zero;

    logic [XLEN-1:0] polar_result;

    int_datapath #(
        .XLEN(XLEN)
    ) int_datapath_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .operator_i      (operator_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .adder_result_o  (adder_result),
        .shift_result_o  (shift_result),
        .shift_result32_o(shift_result32),
        .logic_result_o  (logic_result),
        .less_o          (less),
        .adder_zero_o    (adder_zero)
    );

    polar_simd_unit #(
        .XLEN(XLEN)
    ) polar_simd_unit_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .operator_i    (operator_i),
        .operand_a_i   (operand_a_i),
        .operand_b_i   (operand_b_i),
        .polar_result_o(polar_result)
    );

    alu_result_select #(
        .XLEN(XLEN)
    ) alu_result_select_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .operator_i      (operator_i),
        .adder_result_i  (adder_result),
        .shift_result_i  (shift_result),
        .shift_result32_i(shift_result32),
        .logic_result_i  (logic_result),
        .less_i          (less),
        .adder_zero_i    (adder_zero),
        .polar_result_i  (polar_result),
        .result_o        (result_o),
        .branch_res_o    (branch_res_o)
    );

endmodule

`default_nettype wire

//--- polar_alu_model.svh
`ifndef POLAR_ALU_MODEL_SVH
`define POLAR_ALU_MODEL_SVH

// Reference behavior of the ALU, written from the operation rules

function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
endfunction

// Symmetric clamp to +-127
function automatic logic [7:0] sat_lane(input int v);
    if (v > 127) begin
        return 8'h7f;
    end
    if (v < -127) begin
        return 8'h81;
    end
    return v[7:0];
endfunction

// One 8-bit lane of the per-lane polar ops
function automatic logic [7:0] lane_result(input alu_op_e op, input logic [7:0] a,
                                           input logic [7:0] b, input logic [7:0] b_low);
    int sa;
    int sb;
    int ma;
    int mb;
    int mn;
    sa = int'($signed(a));
    sb = int'($signed(b));
    ma = (sa < 0) ? -sa : sa;
    mb = (sb < 0) ? -sb : sb;
    mn = (ma < mb) ? ma : mb;
    case (op)
        PL_R:      return (b_low == 8'd1) ? 8'd0 : {7'd0, a[7]};
        PL_DECODE: return (b_low == 8'd0) ? a : 8'd0;
        PL_EVAL:   return (a == 8'd1) ? 8'hff : 8'h00;
        PL_F:      return (a[7] != b[7]) ? 8'(-mn) : 8'(mn);
        PL_ADDSAT: return sat_lane(sa + sb);
        PL_SUBSAT: return sat_lane(sa - sb);
        default:   return 8'd0;
    endcase
endfunction

function automatic logic [63:0] expected_result(input alu_op_e op, input logic [63:0] a,
                                                input logic [63:0] b);
    logic [63:0] r;
    r = '0;
    case (op)
        ADD:  r = a + b;
        SUB:  r = a - b;
        ADDW: r = sext32(a[31:0] + b[31:0]);
        SUBW: r = sext32(a[31:0] - b[31:0]);
        XORL: r = a ^ b;
        ORL:  r = a | b;
        ANDL: r = a & b;
        SLL:  r = a << b[5:0];
        SRL:  r = a >> b[5:0];
        SRA:  r = $signed(a) >>> b[5:0];
        SLLW: r = sext32(a[31:0] << b[4:0]);
        SRLW: r = sext32(a[31:0] >> b[4:0]);
        SRAW: r = sext32($signed(a[31:0]) >>> b[4:0]);
        SLTS: r = {63'd0, $signed(a) < $signed(b)};
        SLTU: r = {63'd0, a < b};
        PL_VADDREP1: r = {32'd0, a[31:16] + {{8{b[15]}}, b[15:8]},
                          a[15:0] + {{8{b[7]}}, b[7:0]}};
        PL_VADDREP2: r = {32'd0, a[31:16] + {{8{b[31]}}, b[31:24]},
                          a[15:0] + {{8{b[23]}}, b[23:16]}};
        // Sign flags, MSB byte first: A high, A low, B high, B low
        PL_VREPSUM:  r = {32'd0, 7'd0, a[31], 7'd0, a[15], 7'd0, b[31], 7'd0, b[15]};
        PL_R, PL_F, PL_SUBSAT, PL_ADDSAT, PL_DECODE, PL_EVAL: begin
            for (int i = 0; i < 8; i++) begin
                r[i*8 +: 8] = lane_result(op, a[i*8 +: 8], b[i*8 +: 8], b[7:0]);
            end
        end
        default: r = '0;
    endcase
    return r;
endfunction

// Branch outcome, high for every non-branch operator
function automatic logic expected_branch(input alu_op_e op, input logic [63:0] a,
                                         input logic [63:0] b);
    case (op)
        EQ:      return a == b;
        NE:      return a != b;
        LTS:     return $signed(a) < $signed(b);
        LTU:     return a < b;
        GES:     return $signed(a) >= $signed(b);
        GEU:     return a >= b;
        default: return 1'b1;
    endcase
endfunction

`endif

//--- tb_polar_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_polar_alu;

    import polar_alu_pkg::*;

    localparam int unsigned XLEN = 64;
    localparam int RESET_CYCLES  = 5;
    localparam int RESET_TIMEOUT = 50;
    localparam int SEED          = 7;

    logic            clk;
    logic            rst_n;
    alu_op_e         operator;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] result;
    logic            branch_res;
    int              error_count;
    int              check_count;

    `include "polar_alu_model.svh"

    polar_alu #(
        .XLEN(XLEN)
    ) polar_alu_inst (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .operator_i  (operator),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .result_o    (result),
        .branch_res_o(branch_res)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: actual 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    function automatic logic [63:0] random_word();
        return {$urandom, $urandom};
    endfunction

    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        while ((rst_n !== 1'b1) && (cycles < RESET_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        released = (rst_n === 1'b1);
    endtask

    // Drive one vector, sample on the next edge
    task automatic run_vector(input alu_op_e op, input logic [63:0] a, input logic [63:0] b);
        string name;
        operator  <= op;
        operand_a <= a;
        operand_b <= b;
        @(posedge clk);
        name = op.name();
        check_value({name, " result_o"}, result, expected_result(op, a, b));
        check_value({name, " branch_res_o"}, 64'(branch_res), 64'(expected_branch(op, a, b)));
    endtask

    task automatic run_ops(input alu_op_e ops[], input logic [63:0] a, input logic [63:0] b);
        foreach (ops[i]) begin
            run_vector(ops[i], a, b);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_add_sub_logic();
        alu_op_e ops[];
        ops = '{ADD, SUB, ADDW, SUBW, XORL, ORL, ANDL};
        repeat (8) run_ops(ops, random_word(), random_word());
        run_ops(ops, 64'hffff_ffff_ffff_ffff, 64'h1);
        run_ops(ops, 64'h0000_0000_7fff_ffff, 64'h1);
    endtask

    task automatic test_shifts();
        alu_op_e ops[];
        ops = '{SLL, SRL, SRA, SLLW, SRLW, SRAW};
        repeat (8) run_ops(ops, random_word(), random_word());
        run_ops(ops, 64'h8000_0000_8000_0000, 64'd63);
        run_ops(ops, 64'h0000_0000_8000_0001, 64'd31);
    endtask

    task automatic test_compare_branch();
        alu_op_e     ops[];
        logic [63:0] a;
        ops = '{SLTS, SLTU, EQ, NE, LTS, LTU, GES, GEU, ADD};
        repeat (8) run_ops(ops, random_word(), random_word());
        a = random_word();
        run_ops(ops, a, a);
        run_ops(ops, 64'hffff_ffff_ffff_fffe, 64'h5);
        run_ops(ops, 64'h5, 64'h8000_0000_0000_0000);
    endtask

    task automatic test_lane_ops();
        alu_op_e ops[];
        ops = '{PL_R, PL_DECODE, PL_EVAL, PL_F};
        repeat (8) run_ops(ops, random_word(), random_word());
        // Frozen and zero low byte of B
        run_ops(ops, 64'h81_01_7f_00_80_ff_01_fe, 64'h12_34_56_78_9a_bc_de_01);
        run_ops(ops, 64'h81_01_7f_00_80_ff_01_fe, 64'h80_80_01_ff_80_7f_81_00);
    endtask

    task automatic test_saturation();
        alu_op_e ops[];
        ops = '{PL_ADDSAT, PL_SUBSAT};
        repeat (8) run_ops(ops, random_word(), random_word());
        run_vector(PL_ADDSAT, 64'h7f7f_7f7f_7f7f_7f7f, 64'h0101_0101_0101_0101);
        run_vector(PL_SUBSAT, 64'h8080_8080_8080_8080, 64'h0101_0101_0101_0101);
        run_vector(PL_ADDSAT, 64'h8080_8080_8080_8080, 64'h0);
        run_ops(ops, 64'h8080_7f7f_8080_7f7f, 64'h7f80_807f_8181_7e7e);
    endtask

    task automatic test_replicate();
        alu_op_e ops[];
        ops = '{PL_VADDREP1, PL_VADDREP2, PL_VREPSUM};
        repeat (8) run_ops(ops, random_word(), random_word());
        run_ops(ops, 64'hdead_beef_8000_7fff, 64'h1234_5678_80ff_7f01);
    endtask

    initial begin
        logic reset_seen;
        void'($urandom(SEED));
        operator    = ADD;
        operand_a   = '0;
        operand_b   = '0;
        error_count = 0;
        check_count = 0;
        wait_reset_release(reset_seen);
        if (!reset_seen) begin
            $display("Timeout: reset was never released");
            $display("Simulation failed");
        end else begin
            test_add_sub_logic();
            test_shifts();
            test_compare_branch();
            test_lane_ops();
            test_saturation();
            test_replicate();
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
polar_alu_pkg.sv
int_datapath.sv
polar_simd_unit.sv
alu_result_select.sv
polar_alu.sv
tb_polar_alu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the polar ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_polar_alu \
    -Mdir obj_dir

output=$(./obj_dir/Vtb_polar_alu)
echo "$output"

# Pass only when the testbench reported success
if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi
